/* all.f */
hdl/vector_iir_pkg.sv
hdl/iir_cfg_if.sv
hdl/iir_settings_regs.sv
hdl/vector_index_counter.sv
hdl/iir_ctrl_fsm.sv
hdl/iir_history_ram.sv
hdl/iir_datapath.sv
hdl/vector_iir_top.sv
sim/vector_iir_checker.sv
sim/tb_vector_iir.sv

/* Makefile */
# Verilator build and run of the vector IIR testbench
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_vector_iir -Mdir obj_dir
	./obj_dir/Vtb_vector_iir | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_vector_iir.sv */
/*
 * Testbench for the vector IIR filter. Drives settings and random samples,
 * predicts every output beat with a reference model and checks it.
 */
`timescale 1ns/1ps

module tb_vector_iir;
  import vector_iir_pkg::*;

  logic        clk, rst_n, set_stb, in_last, in_valid, in_ready;
  logic [7:0]  set_addr;
  logic [31:0] set_data, in_data, out_data;
  logic        out_last, out_valid, out_ready;

  // Reference model state
  logic [31:0] history [HIST_DEPTH];
  logic [15:0] model_alpha, model_beta;
  logic [32:0] exp_q [$];
  logic [32:0] exp_beat;
  logic [31:0] data_seed, ready_seed;
  logic        first_pass;
  int          model_len, model_idx, errors, in_count, out_count;

  vector_iir_top u_dut (
    .i_ce_clk (clk), .i_rst_n (rst_n), .i_set_stb (set_stb), .i_set_addr (set_addr),
    .i_set_data (set_data), .i_tdata (in_data), .i_tlast (in_last), .i_tvalid (in_valid),
    .o_tready (in_ready), .o_tdata (out_data), .o_tlast (out_last), .o_tvalid (out_valid),
    .i_tready (out_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One I or Q half: floor of the Q15 sum, clamped to 16 bits
  function automatic logic [15:0] filter_half(input logic signed [15:0] a, h, b, x);
    longint acc;
    longint y;
    acc = longint'(a) * longint'(h) + longint'(b) * longint'(x);
    y   = acc >>> 15;
    if (y > 32767) begin
      y = 32767;
    end else if (y < -32768) begin
      y = -32768;
    end
    return y[15:0];
  endfunction

  //////////////////////////////////////////////////
  // Stimulus and model
  //////////////////////////////////////////////////
  task automatic record_beat(input logic [31:0] d);
    logic [31:0] h;
    logic [31:0] y;
    logic        last;
    h    = first_pass ? 32'h0 : history[model_idx];
    y    = {filter_half(model_alpha, h[31:16], model_beta, d[31:16]),
            filter_half(model_alpha, h[15:0], model_beta, d[15:0])};
    last = (model_idx == model_len - 1);
    exp_q.push_back({last, y});
    history[model_idx] = y;
    if (last) begin
      model_idx  = 0;
      first_pass = 1'b0;
    end else begin
      model_idx++;
    end
    in_count++;
  endtask

  task automatic send_beat(input logic [31:0] d);
    int waited;
    waited = 0;
    in_data  <= d;
    in_last  <= d[0];
    in_valid <= 1'b1;
    @(posedge clk);
    while (!in_ready && waited < 200) begin
      waited++;
      @(posedge clk);
    end
    if (in_ready) begin
      record_beat(d);
    end else begin
      $display("Timeout: input beat %0d was never accepted", in_count);
      errors++;
    end
  endtask

  task automatic send_random(input int n);
    repeat (n) begin
      data_seed = lcg_next(data_seed);
      send_beat(data_seed);
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    in_valid <= 1'b0;
    set_stb  <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    @(posedge clk);
    set_stb <= 1'b0;
    // Restart pulse lands on this edge, so no beat is offered here
    @(posedge clk);
    if (addr == SR_VECTOR_LEN && data[10:0] != 11'd0) begin
      model_len  = int'(data[10:0]);
      model_idx  = 0;
      first_pass = 1'b1;
    end else if (addr == SR_ALPHA) begin
      model_alpha = data[15:0];
    end else if (addr == SR_BETA) begin
      model_beta = data[15:0];
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    in_valid <= 1'b0;
    while (exp_q.size() != 0 && waited < 500) begin
      waited++;
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d output beats never arrived", exp_q.size());
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Back-pressure and output checks
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    ready_seed = lcg_next(ready_seed);
    out_ready <= (ready_seed[17:16] != 2'b00);
  end

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output beat at %0d ns with no matching input", $time);
        errors++;
      end else begin
        exp_beat = exp_q.pop_front();
        assert (out_data == exp_beat[31:0]) else begin
          $display("CHECK FAILED at %0d ns: o_tdata expected %h, got %h",
                   $time, exp_beat[31:0], out_data);
          errors++;
        end
        assert (out_last == exp_beat[32]) else begin
          $display("CHECK FAILED at %0d ns: o_tlast expected %b, got %b",
                   $time, exp_beat[32], out_last);
          errors++;
        end
        out_count++;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    set_stb = 1'b0;
    set_addr = 8'h0;
    set_data = 32'h0;
    in_data = 32'h0;
    in_last = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    errors = 0;
    in_count = 0;
    out_count = 0;
    model_len = 1;
    model_idx = 0;
    first_pass = 1'b1;
    model_alpha = 16'h0000;
    model_beta = 16'h7FFF;
    data_seed = 32'h3bc9;
    ready_seed = lcg_next(32'h3bc9);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Reset settings pass the input through beta only
    send_random(8);
    drain_outputs();
    write_setting(SR_VECTOR_LEN, 32'd8);
    write_setting(SR_ALPHA, 32'h4000);
    write_setting(SR_BETA, 32'h4000);
    send_random(43);
    // Length change part way into a vector, outputs still in flight
    write_setting(SR_VECTOR_LEN, 32'd5);
    send_random(23);
    write_setting(SR_ALPHA, 32'h7FFF);
    write_setting(SR_BETA, 32'h7FFF);
    repeat (10) send_beat(32'h7FFF8000);
    repeat (10) send_beat(32'h80007FFF);
    drain_outputs();
    assert (out_count == in_count) else begin
      $display("CHECK FAILED at %0d ns: output count expected %0d, got %0d",
               $time, in_count, out_count);
      errors++;
    end
    $display("Errors: %0d, inputs: %0d, outputs checked: %0d", errors, in_count, out_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* sim/vector_iir_checker.sv */
/*
 * Concurrent stream protocol assertions, bound into the filter top.
 */
`timescale 1ns/1ps

module vector_iir_checker (
  input logic                                  i_ce_clk,
  input logic                                  i_rst_n,
  input logic [vector_iir_pkg::SAMPLE_W-1:0]   o_tdata,
  input logic                                  o_tvalid,
  input logic                                  o_tready,
  input logic                                  i_tready
);

  // No output beat while reset is held
  a_no_valid_in_reset: assert property (@(posedge i_ce_clk) !i_rst_n |-> !o_tvalid)
    else $error("o_tvalid high during reset");

  // Stalled output keeps valid and data
  a_stall_stable: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata)))
    else $error("output changed while stalled");

  // Full output register blocks the input
  a_stall_blocks_input: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    (o_tvalid && !i_tready) |-> !o_tready)
    else $error("o_tready high while the output is stalled");

endmodule

bind vector_iir_top vector_iir_checker u_checker (.*);

/* hdl/vector_iir_top.sv */
/*
 * Vector IIR filter top level. Settings bus and both sample
 * streams as plain ports; framing comes from the vector length.
 */
`timescale 1ns/1ps

module vector_iir_top (
  input  logic        i_ce_clk,
  input  logic        i_rst_n,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [vector_iir_pkg::SAMPLE_W-1:0] i_tdata,
  // Accepted for protocol compatibility, framing ignores it
  input  logic        i_tlast,
  input  logic        i_tvalid,
  output logic        o_tready,
  output logic [vector_iir_pkg::SAMPLE_W-1:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  logic        i_tready
);
  import vector_iir_pkg::*;

  logic                        beat;
  logic                        restart;
  logic                        use_history;
  logic                        last;
  logic [MAX_LOG2_OF_SIZE-1:0] index;
  sample_t                     history;
  sample_t                     result;

  iir_cfg_if u_cfg ();

  //////////////////////////////////////////////////
  // Configuration and control
  //////////////////////////////////////////////////
  iir_settings_regs u_regs (
    .i_ce_clk   (i_ce_clk),
    .i_rst_n    (i_rst_n),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .cfg        (u_cfg.settings_regs)
  );

  vector_index_counter u_counter (
    .i_ce_clk  (i_ce_clk),
    .i_rst_n   (i_rst_n),
    .i_advance (beat),
    .i_restart (restart),
    .cfg       (u_cfg.consumer),
    .o_index   (index),
    .o_last    (last)
  );

  iir_ctrl_fsm u_fsm (
    .i_ce_clk      (i_ce_clk),
    .i_rst_n       (i_rst_n),
    .i_beat        (beat),
    .i_last        (last),
    .cfg           (u_cfg.consumer),
    .o_restart     (restart),
    .o_use_history (use_history)
  );

  //////////////////////////////////////////////////
  // History and arithmetic
  //////////////////////////////////////////////////
  iir_history_ram u_ram (
    .i_ce_clk (i_ce_clk),
    .i_we     (beat),
    .i_addr   (index),
    .i_wdata  (result),
    .o_rdata  (history)
  );

  iir_datapath u_datapath (
    .i_ce_clk      (i_ce_clk),
    .i_rst_n       (i_rst_n),
    .i_tdata       (i_tdata),
    .i_tvalid      (i_tvalid),
    .o_tready_in   (o_tready),
    .o_tdata       (o_tdata),
    .o_tlast       (o_tlast),
    .o_tvalid      (o_tvalid),
    .i_tready_out  (i_tready),
    .cfg           (u_cfg.consumer),
    .i_use_history (use_history),
    .i_history     (history),
    .i_last        (last),
    .o_beat        (beat),
    .o_result      (result)
  );

endmodule

/* hdl/iir_datapath.sv */
/*
 * Stream handshake and the filter arithmetic, per I/Q half:
 * y = sat16((alpha*y_prev + beta*x) >>> 15), registered once.
 */
`timescale 1ns/1ps

module iir_datapath (
  input  logic i_ce_clk,
  input  logic i_rst_n,
  input  logic [vector_iir_pkg::SAMPLE_W-1:0] i_tdata,
  input  logic i_tvalid,
  output logic o_tready_in,
  output logic [vector_iir_pkg::SAMPLE_W-1:0] o_tdata,
  output logic o_tlast,
  output logic o_tvalid,
  input  logic i_tready_out,
  iir_cfg_if.consumer cfg,
  input  logic i_use_history,
  input  vector_iir_pkg::sample_t i_history,
  input  logic i_last,
  output logic o_beat,
  output vector_iir_pkg::sample_t o_result
);
  import vector_iir_pkg::*;

  sample_t x_in;
  sample_t hist_term;
  sample_t result;
  sample_t out_data;
  logic    out_valid;
  logic    out_last;
  logic    in_fire;

  // Multiply-accumulate, floor shift and saturation for one half
  function automatic logic [IQ_W-1:0] mac_sat(
    input logic signed [COEF_W-1:0] a,
    input logic signed [IQ_W-1:0]   h,
    input logic signed [COEF_W-1:0] b,
    input logic signed [IQ_W-1:0]   x
  );
    logic signed [ACC_W-1:0]           acc;
    logic signed [ACC_W-COEF_FRAC-1:0] shifted;
    acc     = a * h + b * x;
    // Dropping the low bits rounds toward minus infinity
    shifted = acc[ACC_W-1:COEF_FRAC];
    if (shifted[ACC_W-COEF_FRAC-1:IQ_W-1] == '0 ||
        shifted[ACC_W-COEF_FRAC-1:IQ_W-1] == '1) begin
      return shifted[IQ_W-1:0];
    end else if (shifted[ACC_W-COEF_FRAC-1]) begin
      return {1'b1, {(IQ_W-1){1'b0}}};
    end else begin
      return {1'b0, {(IQ_W-1){1'b1}}};
    end
  endfunction

  //////////////////////////////////////////////////
  // Handshake, one output register
  //////////////////////////////////////////////////
  assign o_tready_in = !out_valid || i_tready_out;
  assign in_fire     = i_tvalid && o_tready_in;
  assign o_beat      = in_fire;

  always_comb begin
    x_in.raw      = i_tdata;
    // Zero history on the first pass
    hist_term.raw = i_use_history ? i_history.raw : '0;
    result.iq.i   = mac_sat(cfg.alpha, hist_term.iq.i, cfg.beta, x_in.iq.i);
    result.iq.q   = mac_sat(cfg.alpha, hist_term.iq.q, cfg.beta, x_in.iq.q);
  end

  assign o_result = result;

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
      out_last  <= i_last;
    end else if (i_tready_out) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (in_fire) begin
      out_data <= result;
    end
  end

  assign o_tdata  = out_data.raw;
  assign o_tlast  = out_last;
  assign o_tvalid = out_valid;

endmodule

/* hdl/iir_history_ram.sv */
/*
 * Previous-vector outputs, one word per element position.
 * Written on the clock edge, read combinationally at the same address.
 */
`timescale 1ns/1ps

module iir_history_ram (
  input  logic i_ce_clk,
  input  logic i_we,
  input  logic [vector_iir_pkg::MAX_LOG2_OF_SIZE-1:0] i_addr,
  input  vector_iir_pkg::sample_t i_wdata,
  output vector_iir_pkg::sample_t o_rdata
);
  import vector_iir_pkg::*;

  logic [SAMPLE_W-1:0] mem [HIST_DEPTH];

  always_ff @(posedge i_ce_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata.raw;
    end
  end

  // Read returns the old word when a write to the same address is pending
  assign o_rdata.raw = mem[i_addr];

endmodule

/* hdl/iir_ctrl_fsm.sv */
/*
 * Decides whether the stored history is valid for this vector.
 * The first vector after reset or a length change runs without it.
 */
`timescale 1ns/1ps

module iir_ctrl_fsm (
  input  logic i_ce_clk,
  input  logic i_rst_n,
  input  logic i_beat,
  input  logic i_last,
  iir_cfg_if.consumer cfg,
  output logic o_restart,
  output logic o_use_history
);
  import vector_iir_pkg::*;

  logic state_q;
  logic state_d;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    if (cfg.len_changed) begin
      // New framing, the history no longer lines up
      state_d = ST_FIRST_PASS;
    end else begin
      case (state_q)
        ST_FIRST_PASS: begin
          if (i_beat && i_last) begin
            state_d = ST_STEADY;
          end
        end
        ST_STEADY: state_d = ST_STEADY;
        default:   state_d = ST_FIRST_PASS;
      endcase
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_FIRST_PASS;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  // Index restarts in the same cycle the FSM is sent back
  assign o_restart     = cfg.len_changed;
  assign o_use_history = (state_q == ST_STEADY);

endmodule

/* hdl/vector_index_counter.sv */
/*
 * Element position inside the current vector, with a flag on
 * the last element. Restart takes priority over advance.
 */
`timescale 1ns/1ps

module vector_index_counter (
  input  logic i_ce_clk,
  input  logic i_rst_n,
  input  logic i_advance,
  input  logic i_restart,
  iir_cfg_if.consumer cfg,
  output logic [vector_iir_pkg::MAX_LOG2_OF_SIZE-1:0] o_index,
  output logic o_last
);
  import vector_iir_pkg::*;

  assign o_last = (o_index == cfg.vector_len - 1'b1);

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_index <= '0;
    end else if (i_restart) begin
      o_index <= '0;
    end else if (i_advance) begin
      // Wrap at the end of the vector
      o_index <= o_last ? '0 : o_index + 1'b1;
    end
  end

endmodule

/* hdl/iir_settings_regs.sv */
/*
 * Settings bus decoder. Holds vector length, alpha and beta and
 * pulses len_changed when a non-zero length is written.
 */
`timescale 1ns/1ps

module iir_settings_regs (
  input  logic       i_ce_clk,
  input  logic       i_rst_n,
  input  logic       i_set_stb,
  input  logic [7:0] i_set_addr,
  input  logic [31:0] i_set_data,
  iir_cfg_if.settings_regs cfg
);
  import vector_iir_pkg::*;

  logic [MAX_LOG2_OF_SIZE-1:0] new_len;

  // Length field of the bus word; zero means no change
  assign new_len = i_set_data[MAX_LOG2_OF_SIZE-1:0];

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cfg.vector_len  <= DEFAULT_VECTOR_LEN;
      cfg.alpha       <= DEFAULT_ALPHA;
      cfg.beta        <= DEFAULT_BETA;
      cfg.len_changed <= 1'b0;
    end else begin
      cfg.len_changed <= 1'b0;
      if (i_set_stb) begin
        case (i_set_addr)
          SR_VECTOR_LEN: begin
            if (new_len != '0) begin
              cfg.vector_len  <= new_len;
              cfg.len_changed <= 1'b1;
            end
          end
          SR_ALPHA: cfg.alpha <= i_set_data[COEF_W-1:0];
          SR_BETA:  cfg.beta  <= i_set_data[COEF_W-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

/* hdl/iir_cfg_if.sv */
/*
 * Live filter configuration, driven by the settings registers
 * and read by the counter, the control FSM and the datapath.
 */
`timescale 1ns/1ps

interface iir_cfg_if;
  import vector_iir_pkg::*;

  logic [MAX_LOG2_OF_SIZE-1:0] vector_len;
  logic [COEF_W-1:0]           alpha;
  logic [COEF_W-1:0]           beta;
  // Pulse in the cycle a new length becomes visible
  logic                        len_changed;

  modport settings_regs (
    output vector_len, alpha, beta, len_changed
  );

  modport consumer (
    input vector_len, alpha, beta, len_changed
  );

endinterface

/* hdl/vector_iir_pkg.sv */
/*
 * Shared constants and types for the vector IIR filter.
 * Import inside module bodies, or use scoped names in module headers.
 */
package vector_iir_pkg;

  //////////////////////////////////////////////////
  // Settings bus addresses
  //////////////////////////////////////////////////
  localparam logic [7:0] SR_VECTOR_LEN = 8'd129;
  localparam logic [7:0] SR_ALPHA      = 8'd130;
  localparam logic [7:0] SR_BETA       = 8'd131;

  // Vector length and history depth
  localparam int MAX_LOG2_OF_SIZE = 11;
  localparam int HIST_DEPTH       = 1 << MAX_LOG2_OF_SIZE;

  // Sample and coefficient widths, Q1.15 coefficients
  localparam int SAMPLE_W  = 32;
  localparam int IQ_W      = 16;
  localparam int COEF_W    = 16;
  localparam int COEF_FRAC = 15;

  // Two products summed need one extra bit
  localparam int ACC_W = IQ_W + COEF_W + 1;

  // Values loaded at reset
  localparam logic [MAX_LOG2_OF_SIZE-1:0] DEFAULT_VECTOR_LEN = 11'd1;
  localparam logic [COEF_W-1:0]           DEFAULT_ALPHA      = 16'h0000;
  localparam logic [COEF_W-1:0]           DEFAULT_BETA       = 16'h7FFF;

  // Control FSM state encoding
  localparam logic ST_FIRST_PASS = 1'b0;
  localparam logic ST_STEADY     = 1'b1;

  // One stream word, seen raw or as an I/Q pair (I in the upper half)
  typedef union packed {
    logic [SAMPLE_W-1:0] raw;
    struct packed {
      logic signed [IQ_W-1:0] i;
      logic signed [IQ_W-1:0] q;
    } iq;
  } sample_t;

endpackage
